//--- all.f
+incdir+include
+incdir+tests
rtl/cpu_pkg.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/mycpu_top.sv
tests/tb_mycpu.sv

//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define RESET_PC    32'hBFC00000
`define NUM_REGS    32

// opcodes of the supported subset
`define OP_SPECIAL  6'h00
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0A
`define OP_ANDI     6'h0C
`define OP_ORI      6'h0D
`define OP_LUI      6'h0F
`define OP_LW       6'h23
`define OP_SW       6'h2B

`define FN_SLL      6'h00
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_SLT      6'h2A

`define DST_RD      2'd0    // r-type destination
`define DST_RT      2'd1    // i-type destination
`define DST_RA      2'd2    // jal link register

`define FWD_RF      2'd0    // value read in ID
`define FWD_MEM     2'd1
`define FWD_WB      2'd2

`endif

//--- rtl/alu.sv
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  wire alu_op_e     op_i,
    input  wire [31:0]       a_i,
    input  wire [31:0]       b_i,
    input  wire [4:0]        shamt_i,
    input  wire branch_e     branch_i,
    output logic [31:0]      result_o,
    output logic             taken_o
);

    logic equal;

    assign equal = a_i == b_i;

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLT: result_o = {31'h0, $signed(a_i) < $signed(b_i)};
            ALU_SLL: result_o = b_i << shamt_i;    // shifts rt
            ALU_LUI: result_o = b_i;               // imm already in upper half
            default: result_o = '0;
        endcase
    end

    // branch decision from the forwarded operands
    always_comb begin
        case (branch_i)
            BR_BEQ:  taken_o = equal;
            BR_BNE:  taken_o = !equal;
            BR_JUMP: taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // one fetched word, seen as register or immediate format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JUMP    // j and jal, always taken
    } branch_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       src_b_imm;      // b operand from immediate
        logic       src_a_shamt;    // shift amount from instr field
        logic       reg_wr;
        logic       mem_rd;
        logic       mem_wr;
        logic       wb_link;        // writes pc+8
        branch_e    branch;
        logic [1:0] dst_sel;
    } ctrl_t;

endpackage

`default_nettype wire

//--- rtl/decoder.sv
`default_nettype none

`include "cpu_params.svh"

module decoder
    import cpu_pkg::*;
(
    input  wire instr_t instr_i,
    output ctrl_t       ctrl_o,
    output logic [31:0] imm32_o,
    output logic        uses_rt_o
);

    function automatic logic op_in_subset(input instr_t ins);
        case (ins.i_fmt.op)
            `OP_SPECIAL:
                op_in_subset = ins.r_fmt.funct inside {`FN_SLL, `FN_ADDU, `FN_SUBU,
                    `FN_AND, `FN_OR, `FN_XOR, `FN_SLT};
            `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_ADDIU, `OP_SLTI,
            `OP_ANDI, `OP_ORI, `OP_LUI, `OP_LW, `OP_SW:
                op_in_subset = 1'b1;
            default:
                op_in_subset = 1'b0;
        endcase
    endfunction

    always_comb begin
        ctrl_o    = '0;
        uses_rt_o = 1'b0;
        case (instr_i.i_fmt.op)
            `OP_SPECIAL: begin
                uses_rt_o      = 1'b1;
                ctrl_o.dst_sel = `DST_RD;
                ctrl_o.reg_wr  = 1'b1;
                case (instr_i.r_fmt.funct)
                    `FN_ADDU: ctrl_o.alu_op = ALU_ADD;
                    `FN_SUBU: ctrl_o.alu_op = ALU_SUB;
                    `FN_AND:  ctrl_o.alu_op = ALU_AND;
                    `FN_OR:   ctrl_o.alu_op = ALU_OR;
                    `FN_XOR:  ctrl_o.alu_op = ALU_XOR;
                    `FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    `FN_SLL: begin
                        ctrl_o.alu_op      = ALU_SLL;
                        ctrl_o.src_a_shamt = 1'b1;
                    end
                    default:  ctrl_o.reg_wr = 1'b0;    // unsupported funct
                endcase
            end
            `OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI, `OP_LW: begin
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.reg_wr    = 1'b1;
                ctrl_o.dst_sel   = `DST_RT;
                ctrl_o.mem_rd    = instr_i.i_fmt.op == `OP_LW;
                case (instr_i.i_fmt.op)
                    `OP_SLTI: ctrl_o.alu_op = ALU_SLT;
                    `OP_ANDI: ctrl_o.alu_op = ALU_AND;
                    `OP_ORI:  ctrl_o.alu_op = ALU_OR;
                    `OP_LUI:  ctrl_o.alu_op = ALU_LUI;
                    default:  ctrl_o.alu_op = ALU_ADD;   // addiu, lw
                endcase
            end
            `OP_SW: begin
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.mem_wr    = 1'b1;
                uses_rt_o        = 1'b1;    // store data
            end
            `OP_BEQ: begin
                ctrl_o.branch = BR_BEQ;
                uses_rt_o     = 1'b1;
            end
            `OP_BNE: begin
                ctrl_o.branch = BR_BNE;
                uses_rt_o     = 1'b1;
            end
            `OP_J:   ctrl_o.branch = BR_JUMP;
            `OP_JAL: begin
                ctrl_o.branch  = BR_JUMP;
                ctrl_o.reg_wr  = 1'b1;
                ctrl_o.wb_link = 1'b1;
                ctrl_o.dst_sel = `DST_RA;
            end
            default: ctrl_o = '0;
        endcase

        // an unknown word must never reach the register file or memory
        assert (op_in_subset(instr_i) || !(ctrl_o.reg_wr || ctrl_o.mem_wr));
    end

    always_comb begin
        case (instr_i.i_fmt.op)
            `OP_ANDI, `OP_ORI: imm32_o = {16'h0, instr_i.i_fmt.imm16};    // zero extend
            `OP_LUI:           imm32_o = {instr_i.i_fmt.imm16, 16'h0};
            default:           imm32_o = {{16{instr_i.i_fmt.imm16[15]}}, instr_i.i_fmt.imm16};
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`default_nettype none

`include "cpu_params.svh"

module hazard_unit (
    input  wire [4:0] id_rs_i,
    input  wire [4:0] id_rt_i,
    input  wire       id_uses_rt_i,
    input  wire [4:0] ex_rs_i,
    input  wire [4:0] ex_rt_i,
    input  wire       ex_mem_rd_i,     // load in EXE
    input  wire [4:0] mem_dst_i,
    input  wire       mem_reg_wr_i,
    input  wire [4:0] wb_dst_i,
    input  wire       wb_reg_wr_i,
    input  wire       taken_i,
    output logic       stall_o,
    output logic       flush_o,
    output logic [1:0] fwd_a_o,
    output logic [1:0] fwd_b_o
);

    logic mem_live;
    logic wb_live;

    assign mem_live = mem_reg_wr_i && mem_dst_i != 5'd0;
    assign wb_live  = wb_reg_wr_i && wb_dst_i != 5'd0;

    // younger producer first
    always_comb begin
        if (mem_live && mem_dst_i == ex_rs_i)
            fwd_a_o = `FWD_MEM;
        else if (wb_live && wb_dst_i == ex_rs_i)
            fwd_a_o = `FWD_WB;
        else
            fwd_a_o = `FWD_RF;
        if (mem_live && mem_dst_i == ex_rt_i)
            fwd_b_o = `FWD_MEM;
        else if (wb_live && wb_dst_i == ex_rt_i)
            fwd_b_o = `FWD_WB;
        else
            fwd_b_o = `FWD_RF;
    end

    assign stall_o = ex_mem_rd_i && ex_rt_i != 5'd0
                  && (ex_rt_i == id_rs_i || (id_uses_rt_i && ex_rt_i == id_rt_i));
    assign flush_o = taken_i;    // drop the word fetched after the delay slot

    // load and branch share the EXE slot, so never both
    always_comb begin
        assert (!(stall_o && flush_o));
    end

endmodule

`default_nettype wire

//--- rtl/mycpu_top.sv
`default_nettype none

`include "cpu_params.svh"

module mycpu_top
    import cpu_pkg::*;
(
    input  wire         clk,
    input  wire         rst_i,
    input  wire  [31:0] inst_sram_rdata_i,
    input  wire  [31:0] data_sram_rdata_i,
    output logic        inst_sram_en_o,
    output logic [31:0] inst_sram_addr_o,
    output logic        data_sram_en_o,
    output logic [3:0]  data_sram_wen_o,
    output logic [31:0] data_sram_addr_o,
    output logic [31:0] data_sram_wdata_o,
    output logic [31:0] debug_wb_pc_o,
    output logic [3:0]  debug_wb_rf_wen_o,
    output logic [4:0]  debug_wb_rf_wnum_o,
    output logic [31:0] debug_wb_rf_wdata_o
);

    logic        run_q;
    logic [31:0] pc;
    logic        if_valid;
    logic [31:0] npc;
    logic        pc_adv;
    logic        stall;
    logic        flush;

    logic [31:0] id_pc;
    instr_t      id_instr;
    logic        id_valid;
    ctrl_t       id_ctrl;
    logic [31:0] id_imm32;
    logic        id_uses_rt;
    logic [31:0] id_a;
    logic [31:0] id_b;

    logic [31:0] ex_pc;
    instr_t      ex_instr;
    logic        ex_valid;
    ctrl_t       ex_ctrl;
    logic [31:0] ex_imm32;
    logic [31:0] ex_a;
    logic [31:0] ex_b;
    logic [1:0]  fwd_a;
    logic [1:0]  fwd_b;
    logic [31:0] ex_fa;
    logic [31:0] ex_fb;
    logic [31:0] ex_alu;
    logic        ex_taken;
    logic [4:0]  ex_dst;
    logic [31:0] ex_pc4;
    logic [31:0] redirect;

    logic [31:0] mem_pc;
    logic        mem_valid;
    ctrl_t       mem_ctrl;
    logic [31:0] mem_alu;
    logic [4:0]  mem_dst;
    logic [31:0] mem_fwd;

    logic [31:0] wb_pc;
    logic        wb_valid;
    ctrl_t       wb_ctrl;
    logic [31:0] wb_alu;
    logic [31:0] wb_load;
    logic [4:0]  wb_dst;
    logic [31:0] wb_data;
    logic        wb_we;

    function automatic logic [31:0] fwd_pick(input logic [1:0] sel, input logic [31:0] rf,
                                             input logic [31:0] mem, input logic [31:0] wb);
        case (sel)
            `FWD_MEM: fwd_pick = mem;
            `FWD_WB:  fwd_pick = wb;
            default:  fwd_pick = rf;
        endcase
    endfunction

    // IF
    always_ff @(posedge clk) begin
        if (rst_i) begin
            run_q    <= 1'b0;
            pc       <= `RESET_PC - 32'd4;    // first advance lands on reset pc
            if_valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (pc_adv) begin
                pc       <= npc;
                if_valid <= 1'b1;
            end
        end
    end

    assign pc_adv           = run_q && !stall;
    assign npc              = flush ? redirect : (pc_adv ? pc + 32'd4 : pc);
    assign inst_sram_addr_o = npc;
    assign inst_sram_en_o   = pc_adv;

    // IF/ID, held on stall
    always_ff @(posedge clk) begin
        if (rst_i)
            id_valid <= 1'b0;
        else if (!stall)
            id_valid <= if_valid && !flush;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc    <= pc;
            id_instr <= inst_sram_rdata_i;
        end
    end

    // ID
    decoder u_decoder (
        .instr_i   (id_instr),
        .ctrl_o    (id_ctrl),
        .imm32_o   (id_imm32),
        .uses_rt_o (id_uses_rt)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_i     (rst_i),
        .we_i      (wb_we),
        .waddr_i   (wb_dst),
        .wdata_i   (wb_data),
        .raddr_a_i (id_instr.i_fmt.rs),
        .raddr_b_i (id_instr.i_fmt.rt),
        .rdata_a_o (id_a),
        .rdata_b_o (id_b)
    );

    hazard_unit u_hazard_unit (
        .id_rs_i      (id_instr.i_fmt.rs),
        .id_rt_i      (id_instr.i_fmt.rt),
        .id_uses_rt_i (id_uses_rt),
        .ex_rs_i      (ex_instr.i_fmt.rs),
        .ex_rt_i      (ex_instr.i_fmt.rt),
        .ex_mem_rd_i  (ex_ctrl.mem_rd),
        .mem_dst_i    (mem_dst),
        .mem_reg_wr_i (mem_valid && mem_ctrl.reg_wr),
        .wb_dst_i     (wb_dst),
        .wb_reg_wr_i  (wb_we),
        .taken_i      (ex_taken),
        .stall_o      (stall),
        .flush_o      (flush),
        .fwd_a_o      (fwd_a),
        .fwd_b_o      (fwd_b)
    );

    // ID/EXE, bubble on stall
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid <= 1'b0;
            ex_ctrl  <= '0;
        end else begin
            ex_valid <= id_valid && !stall;
            ex_ctrl  <= (id_valid && !stall) ? id_ctrl : '0;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc    <= id_pc;
        ex_instr <= id_instr;
        ex_imm32 <= id_imm32;
        ex_a     <= id_a;
        ex_b     <= id_b;
    end

    // EXE
    assign ex_fa = fwd_pick(fwd_a, ex_a, mem_fwd, wb_data);
    assign ex_fb = fwd_pick(fwd_b, ex_b, mem_fwd, wb_data);

    alu u_alu (
        .op_i     (ex_ctrl.alu_op),
        .a_i      (ex_fa),
        .b_i      (ex_ctrl.src_b_imm ? ex_imm32 : ex_fb),
        .shamt_i  (ex_ctrl.src_a_shamt ? ex_instr.r_fmt.shamt : ex_fa[4:0]),
        .branch_i (ex_ctrl.branch),
        .result_o (ex_alu),
        .taken_o  (ex_taken)
    );

    assign ex_pc4   = ex_pc + 32'd4;    // delay slot pc
    assign redirect = (ex_ctrl.branch == BR_JUMP)
                    ? {ex_pc4[31:28], ex_instr[25:0], 2'b00}
                    : ex_pc4 + {ex_imm32[29:0], 2'b00};

    always_comb begin
        case (ex_ctrl.dst_sel)
            `DST_RT: ex_dst = ex_instr.i_fmt.rt;
            `DST_RA: ex_dst = 5'd31;
            default: ex_dst = ex_instr.r_fmt.rd;
        endcase
    end

    assign data_sram_en_o    = ex_valid && (ex_ctrl.mem_rd || ex_ctrl.mem_wr);
    assign data_sram_wen_o   = (ex_valid && ex_ctrl.mem_wr) ? 4'hF : 4'h0;
    assign data_sram_addr_o  = ex_alu;
    assign data_sram_wdata_o = ex_fb;    // forwarded rt

    // EXE/MEM
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_valid <= 1'b0;
            mem_ctrl  <= '0;
        end else begin
            mem_valid <= ex_valid;
            mem_ctrl  <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        mem_pc  <= ex_pc;
        mem_alu <= ex_alu;
        mem_dst <= ex_dst;
    end

    assign mem_fwd = mem_ctrl.wb_link ? mem_pc + 32'd8 : mem_alu;    // loads never forward here

    // MEM/WB
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid <= 1'b0;
            wb_ctrl  <= '0;
        end else begin
            wb_valid <= mem_valid;
            wb_ctrl  <= mem_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc   <= mem_pc;
        wb_alu  <= mem_alu;
        wb_load <= data_sram_rdata_i;
        wb_dst  <= mem_dst;
    end

    // WB
    always_comb begin
        if (wb_ctrl.mem_rd)
            wb_data = wb_load;
        else if (wb_ctrl.wb_link)
            wb_data = wb_pc + 32'd8;
        else
            wb_data = wb_alu;
    end

    assign wb_we = wb_valid && wb_ctrl.reg_wr;

    assign debug_wb_pc_o       = wb_pc;
    assign debug_wb_rf_wen_o   = (wb_we && wb_dst != 5'd0) ? 4'hF : 4'h0;
    assign debug_wb_rf_wnum_o  = wb_dst;
    assign debug_wb_rf_wdata_o = wb_data;

    a_wen_needs_en: assert property (@(posedge clk) disable iff (rst_i)
        data_sram_wen_o != 4'h0 |-> data_sram_en_o);

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`default_nettype none

`include "cpu_params.svh"

module reg_file (
    input  wire        clk,
    input  wire        rst_i,
    input  wire        we_i,
    input  wire [4:0]  waddr_i,
    input  wire [31:0] wdata_i,
    input  wire [4:0]  raddr_a_i,
    input  wire [4:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    logic [31:0] regs [`NUM_REGS];
    logic        wr_live;

    assign wr_live = we_i && waddr_i != 5'd0;    // r0 is never stored

    always_ff @(posedge clk) begin
        if (rst_i) begin
            regs[0] <= '0;    // r0 reads from storage like the rest
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle writeback wins over the stored value
    always_comb begin
        if (wr_live && waddr_i == raddr_a_i)
            rdata_a_o = wdata_i;
        else
            rdata_a_o = regs[raddr_a_i];
        if (wr_live && waddr_i == raddr_b_i)
            rdata_b_o = wdata_i;
        else
            rdata_b_o = regs[raddr_b_i];
    end

    // a write aimed at r0 must leave the stored zero in place
    a_r0_stays_zero: assert property (@(posedge clk) disable iff (rst_i)
        we_i && waddr_i == 5'd0 |=> regs[0] == '0);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_mycpu -f all.f --Mdir obj_dir -o sim_tb_mycpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_mycpu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

//--- tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [31:0] r_ins(input logic [5:0] funct, input int rs, input int rt,
                                      input int rd, input int shamt);
    return {`OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
endfunction

function automatic logic [31:0] i_ins(input logic [5:0] op, input int rs, input int rt,
                                      input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
endfunction

function automatic void emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len = prog_len + 10'd1;
endfunction

// branch offset counts from the delay slot
function automatic void emit_branch(input logic [5:0] op, input int rs, input int rt,
                                    input int target);
    logic [15:0] off;
    off = 16'(target - int'(prog_len) - 1);
    emit(i_ins(op, rs, rt, off));
endfunction

function automatic void emit_jump(input logic [5:0] op, input int target);
    logic [31:0] t;
    t = (`RESET_PC >> 2) + 32'(target);
    emit({op, t[25:0]});
endfunction

function automatic void load_const(input int r, input logic [31:0] v);
    emit(i_ins(`OP_LUI, 0, r, v[31:16]));
    emit(i_ins(`OP_ORI, r, r, v[15:0]));
endfunction

// steps the program word by word with one delay slot, stops at the halt loop
function automatic void run_ref_model(input logic [31:0] halt_pc);
    instr_t      ins;
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] nnpc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    logic [31:0] res;
    logic [31:0] addr;
    logic [4:0]  dst;
    logic        wr;
    int          steps;
    pc = `RESET_PC;
    npc = pc + 32'd4;
    steps = 0;
    while (pc != halt_pc && steps < 4000) begin
        ins = imem[pc[11:2]];
        a = ref_regs[ins.i_fmt.rs];
        b = ref_regs[ins.i_fmt.rt];
        sx = {{16{ins.i_fmt.imm16[15]}}, ins.i_fmt.imm16};
        zx = {16'h0, ins.i_fmt.imm16};
        addr = a + sx;
        nnpc = npc + 32'd4;
        wr = 1'b1;
        dst = ins.i_fmt.rt;
        res = '0;
        case (ins.i_fmt.op)
            `OP_SPECIAL: begin
                dst = ins.r_fmt.rd;
                case (ins.r_fmt.funct)
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_XOR:  res = a ^ b;
                    `FN_SLT:  res = {31'h0, $signed(a) < $signed(b)};
                    `FN_SLL:  res = b << ins.r_fmt.shamt;
                    default:  wr = 1'b0;
                endcase
            end
            `OP_ADDIU: res = a + sx;
            `OP_SLTI:  res = {31'h0, $signed(a) < $signed(sx)};
            `OP_ANDI:  res = a & zx;
            `OP_ORI:   res = a | zx;
            `OP_LUI:   res = {ins.i_fmt.imm16, 16'h0};
            `OP_LW:    res = ref_dmem[addr[11:2]];
            `OP_SW: begin
                wr = 1'b0;
                ref_dmem[addr[11:2]] = b;
            end
            `OP_BEQ: begin
                wr = 1'b0;
                if (a == b)
                    nnpc = pc + 32'd4 + (sx << 2);
            end
            `OP_BNE: begin
                wr = 1'b0;
                if (a != b)
                    nnpc = pc + 32'd4 + (sx << 2);
            end
            `OP_J: begin
                wr = 1'b0;
                nnpc = {npc[31:28], ins.i_fmt.rs, ins.i_fmt.rt, ins.i_fmt.imm16, 2'b00};
            end
            `OP_JAL: begin
                dst = 5'd31;
                res = pc + 32'd8;
                nnpc = {npc[31:28], ins.i_fmt.rs, ins.i_fmt.rt, ins.i_fmt.imm16, 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            ref_regs[dst] = res;
            exp_pc.push_back(pc);
            exp_num.push_back(dst);
            exp_data.push_back(res);
        end
        pc = npc;
        npc = nnpc;
        steps++;
    end
endfunction

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

`endif

//--- tests/tb_mycpu.sv
`default_nettype none

`include "cpu_params.svh"

module tb_mycpu
    import cpu_pkg::*;
();

    logic        clk;
    logic        rst_i;
    logic [31:0] inst_rdata;
    logic [31:0] data_rdata;
    wire         inst_sram_en_o;
    wire  [31:0] inst_sram_addr_o;
    wire         data_sram_en_o;
    wire  [3:0]  data_sram_wen_o;
    wire  [31:0] data_sram_addr_o;
    wire  [31:0] data_sram_wdata_o;
    wire  [31:0] debug_wb_pc_o;
    wire  [3:0]  debug_wb_rf_wen_o;
    wire  [4:0]  debug_wb_rf_wnum_o;
    wire  [31:0] debug_wb_rf_wdata_o;

    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    logic [31:0] ref_dmem [1024];
    logic [31:0] ref_regs [32];
    logic [9:0]  prog_len;
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    integer      seed = 32'h6ac9;
    int          errors;
    int          tests_ok;

    // sram request captured at posedge, served at the next negedge
    logic        inst_en_q;
    logic [31:0] inst_addr_q;
    logic        data_en_q;
    logic [3:0]  data_wen_q;
    logic [31:0] data_addr_q;
    logic [31:0] data_wdata_q;

    `include "tb_ref_model.svh"

    mycpu_top UUT (
        .clk                 (clk),
        .rst_i               (rst_i),
        .inst_sram_rdata_i   (inst_rdata),
        .data_sram_rdata_i   (data_rdata),
        .inst_sram_en_o      (inst_sram_en_o),
        .inst_sram_addr_o    (inst_sram_addr_o),
        .data_sram_en_o      (data_sram_en_o),
        .data_sram_wen_o     (data_sram_wen_o),
        .data_sram_addr_o    (data_sram_addr_o),
        .data_sram_wdata_o   (data_sram_wdata_o),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        inst_en_q    <= inst_sram_en_o;
        inst_addr_q  <= inst_sram_addr_o;
        data_en_q    <= data_sram_en_o;
        data_wen_q   <= data_sram_wen_o;
        data_addr_q  <= data_sram_addr_o;
        data_wdata_q <= data_sram_wdata_o;
    end

    always @(negedge clk) begin
        if (inst_en_q)
            inst_rdata <= imem[inst_addr_q[11:2]];
        if (data_en_q) begin
            data_rdata <= dmem[data_addr_q[11:2]];    // old word on a store
            if (data_wen_q != 4'h0)
                dmem[data_addr_q[11:2]] <= data_wdata_q;
        end
    end

    task automatic build_program(input int t);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        prog_len = 10'd0;
        for (int i = 0; i < 1024; i++) begin
            imem[i[9:0]] = 32'h0;    // nop
            dmem[i[9:0]] = 32'(i) * 32'h9E3779B1 ^ 32'hC3A50F1E;
        end
        case (t)
            0: begin
                load_const(1, a);
                load_const(2, b);
                emit(r_ins(`FN_ADDU, 1, 2, 3, 0));
                emit(r_ins(`FN_SUBU, 1, 2, 4, 0));
                emit(r_ins(`FN_AND, 1, 2, 5, 0));
                emit(r_ins(`FN_OR, 1, 2, 6, 0));
                emit(r_ins(`FN_XOR, 1, 2, 7, 0));
                emit(r_ins(`FN_SLT, 1, 2, 8, 0));
                emit(r_ins(`FN_SLT, 2, 1, 9, 0));
                emit(r_ins(`FN_SLL, 0, 1, 10, 7));
                emit(i_ins(`OP_ADDIU, 1, 11, c[15:0]));
                emit(i_ins(`OP_SLTI, 1, 12, c[31:16]));
                emit(i_ins(`OP_ANDI, 1, 13, c[15:0]));
                emit(i_ins(`OP_ORI, 2, 14, c[31:16]));
                emit(i_ins(`OP_LUI, 0, 15, c[15:0]));
            end
            1: begin
                load_const(1, a);
                emit(r_ins(`FN_ADDU, 1, 1, 2, 0));
                emit(r_ins(`FN_SUBU, 2, 1, 3, 0));    // r2 from MEM, r1 from WB
                emit(r_ins(`FN_XOR, 3, 2, 4, 0));
                emit(i_ins(`OP_ADDIU, 4, 5, b[15:0]));
                emit(r_ins(`FN_OR, 5, 3, 6, 0));
                emit(r_ins(`FN_SLL, 0, 6, 7, 3));
                emit(r_ins(`FN_AND, 7, 5, 8, 0));
            end
            2: begin
                emit(i_ins(`OP_ADDIU, 0, 1, 16'h0100));
                emit(i_ins(`OP_LW, 1, 2, 16'h0000));
                emit(r_ins(`FN_ADDU, 2, 2, 3, 0));    // load-use
                load_const(4, a);
                emit(i_ins(`OP_SW, 1, 4, 16'h0008));
                emit(i_ins(`OP_LW, 1, 5, 16'h0008));
                emit(r_ins(`FN_OR, 5, 0, 6, 0));
                emit(i_ins(`OP_LW, 1, 7, 16'h0004));
                emit(i_ins(`OP_SW, 1, 7, 16'h000C));    // store data from a load
                emit(i_ins(`OP_LW, 1, 8, 16'h000C));
                emit(r_ins(`FN_SUBU, 8, 3, 9, 0));
            end
            3: begin
                b = a ^ (c | 32'h1);
                load_const(1, a);
                load_const(2, a);
                load_const(3, b);
                emit_branch(`OP_BEQ, 1, 2, 9);    // taken
                emit(i_ins(`OP_ADDIU, 0, 4, 16'h0001));
                emit(i_ins(`OP_ADDIU, 0, 5, 16'h0002));
                emit_branch(`OP_BNE, 1, 3, 12);    // taken
                emit(i_ins(`OP_ADDIU, 0, 6, 16'h0003));
                emit(i_ins(`OP_ADDIU, 0, 7, 16'h0004));
                emit_branch(`OP_BEQ, 1, 3, 15);    // not taken
                emit(i_ins(`OP_ADDIU, 0, 8, 16'h0005));
                emit(i_ins(`OP_ADDIU, 0, 9, 16'h0006));
                emit_branch(`OP_BNE, 1, 2, 18);    // not taken
                emit(i_ins(`OP_ADDIU, 0, 10, 16'h0007));
                emit(i_ins(`OP_ADDIU, 0, 11, 16'h0008));
            end
            4: begin
                emit_jump(`OP_JAL, 4);
                emit(i_ins(`OP_ADDIU, 0, 1, 16'h000B));
                emit(i_ins(`OP_ADDIU, 0, 2, 16'h000C));
                emit(i_ins(`OP_ADDIU, 0, 3, 16'h000D));
                emit(r_ins(`FN_ADDU, 31, 0, 4, 0));
                emit_jump(`OP_J, 8);
                emit(i_ins(`OP_ADDIU, 0, 5, 16'h000E));
                emit(i_ins(`OP_ADDIU, 0, 6, 16'h000F));
                emit(i_ins(`OP_ADDIU, 31, 7, 16'h0004));
            end
            default: begin
                load_const(1, a);
                emit(i_ins(`OP_ADDIU, 1, 0, 16'h0005));
                emit(r_ins(`FN_ADDU, 1, 1, 0, 0));
                emit(r_ins(`FN_OR, 0, 0, 2, 0));
                emit(i_ins(`OP_LW, 0, 0, 16'h0020));
                emit(r_ins(`FN_ADDU, 0, 1, 3, 0));
                emit(r_ins(`FN_ADDU, 0, 0, 4, 0));
            end
        endcase
        emit_branch(`OP_BEQ, 0, 0, int'(prog_len));    // halt loop
        emit(32'h0);
    endtask

    task automatic wait_trace(output logic found);
        int n;
        n = 0;
        found = 1'b0;
        while (!found && n < 500) begin
            @(negedge clk);
            if (debug_wb_rf_wen_o != 4'h0)
                found = 1'b1;
            n++;
        end
    endtask

    task automatic run_test(input int t, input string name);
        int   errs_before;
        logic found;
        logic [31:0] halt_pc;
        errs_before = errors;
        @(negedge clk);
        rst_i = 1'b1;
        repeat (2) @(negedge clk);
        build_program(t);
        for (int i = 0; i < 1024; i++)
            ref_dmem[i[9:0]] = dmem[i[9:0]];
        halt_pc = `RESET_PC + {20'h0, prog_len - 10'd2, 2'b00};
        run_ref_model(halt_pc);
        repeat (14) begin    // sram ports stay quiet in reset
            @(negedge clk);
            check_equal({31'h0, inst_sram_en_o}, 32'h0, "fetch enable in reset");
            check_equal({27'h0, data_sram_en_o, data_sram_wen_o}, 32'h0,
                        "data enables in reset");
        end
        rst_i = 1'b0;
        while (exp_pc.size() > 0) begin
            wait_trace(found);
            if (!found) begin
                $display("test %0d: trace stalled with %0d writebacks missing", t, exp_pc.size());
                errors++;
                exp_pc.delete();
                exp_num.delete();
                exp_data.delete();
            end else begin
                check_equal(debug_wb_pc_o, exp_pc.pop_front(), "trace pc");
                check_equal({27'h0, debug_wb_rf_wnum_o}, {27'h0, exp_num.pop_front()},
                            "trace wnum");
                check_equal(debug_wb_rf_wdata_o, exp_data.pop_front(), "trace wdata");
            end
        end
        repeat (40) begin    // nothing more may retire
            @(negedge clk);
            if (debug_wb_rf_wen_o != 4'h0) begin
                $display("test %0d: unexpected write of r%0d at pc %h", t,
                         debug_wb_rf_wnum_o, debug_wb_pc_o);
                errors++;
            end
        end
        for (int i = 0; i < 1024; i++)
            check_equal(dmem[i[9:0]], ref_dmem[i[9:0]], "data memory word");
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %0d %s: ok", t, name);
        end else begin
            $display("test %0d %s: FAILED", t, name);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        inst_rdata = '0;
        data_rdata = '0;
        errors = 0;
        tests_ok = 0;
        for (int r = 0; r < 32; r++)
            ref_regs[r] = '0;
        run_test(0, "alu ops");
        run_test(1, "forwarding");
        run_test(2, "loads and stores");
        run_test(3, "branches");
        run_test(4, "jumps");
        run_test(5, "register zero");
        $display("%0d of 6 tests ok, %0d check errors", tests_ok, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
